// File: src/merge_config.svh
// --------------------
// Sizes of the bitonic merge network, included by packages and stages
// --------------------
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// Bits per unsigned sort key
`define MERGE_KEY_WIDTH 32

// Keys per group, must be a power of two
`define MERGE_HALF_LANES 8

// One split stage plus log2 of the group size
`define MERGE_STAGES 4

`endif

// File: src/key_pkg.sv
// --------------------
// Sort key type and compare-and-swap helpers
// --------------------
`include "merge_config.svh"

package key_pkg;

   typedef logic [`MERGE_KEY_WIDTH-1:0] key_t;

   // Unsigned compare, ties keep the first operand
   function automatic key_t key_min(input key_t a, input key_t b);
      return (a > b) ? b : a;
   endfunction

   function automatic key_t key_max(input key_t a, input key_t b);
      return (a > b) ? a : b;
   endfunction

endpackage

// File: src/network_pkg.sv
// --------------------
// Lane group types and stride helpers for the merge network
// --------------------
`include "merge_config.svh"

package network_pkg;
   import key_pkg::*;

   // Lane 0 holds the smallest key once a group is sorted
   typedef key_t [`MERGE_HALF_LANES-1:0] lanes_t;

   // Switch flag riding along with each beat
   typedef logic beat_flag_t;

   // Lower member of a pair when the stride bit is clear
   function automatic bit is_lower_lane(input int lane, input int stride);
      return (lane & stride) == 0;
   endfunction

   function automatic int partner_lane(input int lane, input int stride);
      return lane + stride;
   endfunction

   function automatic key_t group_max(input lanes_t g);
      key_t m;
      m = g[0];
      for (int i = 1; i < `MERGE_HALF_LANES; i++) begin
         m = key_max(m, g[i]);
      end
      return m;
   endfunction

   function automatic key_t group_min(input lanes_t g);
      key_t m;
      m = g[0];
      for (int i = 1; i < `MERGE_HALF_LANES; i++) begin
         m = key_min(m, g[i]);
      end
      return m;
   endfunction

endpackage

// File: src/merge_stage_if.sv
// --------------------
// One beat passed between pipeline stages, producer drives through drv
// --------------------
`timescale 1ns/1ns

interface merge_stage_if;
   import network_pkg::*;

   lanes_t     lo;
   lanes_t     hi;
   beat_flag_t flag;
   // High marks a bubble, no new data on lo, hi and flag
   logic       stall;

   modport drv (
      output lo,
      output hi,
      output flag,
      output stall
   );

   modport rcv (
      input lo,
      input hi,
      input flag,
      input stall
   );

endinterface

// File: src/bitonic_split_stage.sv
// --------------------
// First merge stage, folds two sorted groups into two bitonic halves
// --------------------
`timescale 1ns/1ns
`include "merge_config.svh"

module bitonic_split_stage (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_stall,
   input  network_pkg::beat_flag_t i_switch_output,
   input  network_pkg::lanes_t   i_elems_lo,
   input  network_pkg::lanes_t   i_elems_hi,
   merge_stage_if.drv            o_beat
);
   import key_pkg::*;
   import network_pkg::*;

   localparam int LANES = `MERGE_HALF_LANES;

   lanes_t     lo_next;
   lanes_t     hi_next;
   lanes_t     lo_q;
   lanes_t     hi_q;
   beat_flag_t flag_q;
   logic       stall_q;

   // Low lane i against high lane LANES-1-i
   always_comb begin
      lo_next = '0;
      hi_next = '0;
      for (int i = 0; i < LANES; i++) begin
         lo_next[i]         = key_min(i_elems_lo[i], i_elems_hi[LANES-1-i]);
         hi_next[LANES-1-i] = key_max(i_elems_lo[i], i_elems_hi[LANES-1-i]);
      end
   end

   // Stall token moves every cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         stall_q <= 1'b1;
         flag_q  <= 1'b0;
      end else begin
         stall_q <= i_stall;
         if (!i_stall) begin
            flag_q <= i_switch_output;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_stall) begin
         lo_q <= lo_next;
         hi_q <= hi_next;
      end
   end

   assign o_beat.lo    = lo_q;
   assign o_beat.hi    = hi_q;
   assign o_beat.flag  = flag_q;
   assign o_beat.stall = stall_q;

   // Whole low group ends up at or below the whole high group
   a_split_order: assert property (
      @(posedge i_clk) disable iff (i_rst)
      !i_stall |=> (group_max(lo_q) <= group_min(hi_q))
   );

endmodule

// File: src/half_cleaner_stage.sv
// --------------------
// Half-cleaner stage of a given stride, applied to each group separately
// --------------------
`timescale 1ns/1ns
`include "merge_config.svh"

module half_cleaner_stage #(
   parameter int STRIDE = 1
) (
   input  logic       i_clk,
   input  logic       i_rst,
   merge_stage_if.rcv i_beat,
   merge_stage_if.drv o_beat
);
   import key_pkg::*;
   import network_pkg::*;

   localparam int LANES = `MERGE_HALF_LANES;

   lanes_t     lo_q;
   lanes_t     hi_q;
   beat_flag_t flag_q;
   logic       stall_q;

   // Compare each lower lane with the lane STRIDE above it
   function automatic lanes_t clean_group(input lanes_t g);
      lanes_t r;
      int     p;
      r = g;
      for (int i = 0; i < LANES; i++) begin
         if (is_lower_lane(i, STRIDE)) begin
            p    = partner_lane(i, STRIDE);
            r[i] = key_min(g[i], g[p]);
            r[p] = key_max(g[i], g[p]);
         end
      end
      return r;
   endfunction

   // Lower half of each block never above its upper half when the input is bitonic
   function automatic bit halves_ordered(input lanes_t g);
      bit ok;
      ok = 1'b1;
      for (int i = 0; i < LANES; i++) begin
         for (int j = 0; j < LANES; j++) begin
            if (is_lower_lane(i, STRIDE) && !is_lower_lane(j, STRIDE) &&
                (i / (2 * STRIDE)) == (j / (2 * STRIDE))) begin
               ok = ok && (g[i] <= g[j]);
            end
         end
      end
      return ok;
   endfunction

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         stall_q <= 1'b1;
         flag_q  <= 1'b0;
      end else begin
         stall_q <= i_beat.stall;
         if (!i_beat.stall) begin
            flag_q <= i_beat.flag;
         end
      end
   end

   // Keys held across bubbles
   always_ff @(posedge i_clk) begin
      if (!i_beat.stall) begin
         lo_q <= clean_group(i_beat.lo);
         hi_q <= clean_group(i_beat.hi);
      end
   end

   assign o_beat.lo    = lo_q;
   assign o_beat.hi    = hi_q;
   assign o_beat.flag  = flag_q;
   assign o_beat.stall = stall_q;

   a_halves_ordered: assert property (
      @(posedge i_clk) disable iff (i_rst)
      !i_beat.stall |=> (halves_ordered(lo_q) && halves_ordered(hi_q))
   );

   // Bubble comes out of reset
   a_reset_stall: assert property (
      @(posedge i_clk) i_rst |=> stall_q
   );

endmodule

// File: src/bitonic_merge_top.sv
// --------------------
// Four stage bitonic merge of two sorted key groups, four cycle latency
// --------------------
`timescale 1ns/1ns

module bitonic_merge_top (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_stall,
   input  logic                i_switch_output,
   input  network_pkg::lanes_t i_elems_lo,
   input  network_pkg::lanes_t i_elems_hi,
   output network_pkg::lanes_t o_elems_lo,
   output network_pkg::lanes_t o_elems_hi,
   output logic                o_switch_output,
   output logic                o_stall
);

   // One interface after each stage
   merge_stage_if s1_beat ();
   merge_stage_if s2_beat ();
   merge_stage_if s3_beat ();
   merge_stage_if s4_beat ();

   bitonic_split_stage u_split (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_stall         (i_stall),
      .i_switch_output (i_switch_output),
      .i_elems_lo      (i_elems_lo),
      .i_elems_hi      (i_elems_hi),
      .o_beat          (s1_beat)
   );

   // Strides halve down to neighbour compares
   half_cleaner_stage #(
      .STRIDE (4)
   ) u_clean_4 (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_beat (s1_beat),
      .o_beat (s2_beat)
   );

   half_cleaner_stage #(
      .STRIDE (2)
   ) u_clean_2 (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_beat (s2_beat),
      .o_beat (s3_beat)
   );

   half_cleaner_stage #(
      .STRIDE (1)
   ) u_clean_1 (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_beat (s3_beat),
      .o_beat (s4_beat)
   );

   assign o_elems_lo      = s4_beat.lo;
   assign o_elems_hi      = s4_beat.hi;
   assign o_switch_output = s4_beat.flag;
   assign o_stall         = s4_beat.stall;

endmodule

// File: bench/merge_ref_check.sv
// --------------------
// Reference queue and output assertions, bound to the merge top-level ports
// --------------------
`timescale 1ns/1ns
`include "merge_config.svh"

module merge_ref_check (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_stall,
   input  logic                i_flag,
   input  logic [2*`MERGE_HALF_LANES*`MERGE_KEY_WIDTH-1:0] i_exp_keys,
   input  network_pkg::lanes_t i_out_lo,
   input  network_pkg::lanes_t i_out_hi,
   input  logic                i_out_flag,
   input  logic                i_out_stall,
   output int                  o_errors,
   output int                  o_pending
);
   import network_pkg::*;

   localparam int KW    = `MERGE_KEY_WIDTH;
   localparam int EXP_W = 2 * `MERGE_HALF_LANES * KW;

   // Flag on top of the sixteen sorted keys
   logic [EXP_W:0]           ref_q[$];
   logic [EXP_W:0]           front;
   logic                     have_front;
   logic                     out_seen;
   logic [`MERGE_STAGES-1:0] stall_pipe;
   logic [EXP_W-1:0]         out_keys;
   int                       error_count = 0;

   assign out_keys = {i_out_hi, i_out_lo};
   assign o_errors = error_count;

   task automatic count_mismatch(input string msg);
      error_count++;
      $display("MISMATCH %0t: %s", $time, msg);
   endtask

   function automatic bit keys_ascending(input logic [EXP_W-1:0] k);
      bit ok;
      ok = 1'b1;
      for (int i = 1; i < EXP_W / KW; i++) begin
         if (k[i*KW +: KW] < k[(i-1)*KW +: KW]) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   // Push accepted beats, pop the oldest when it leaves the pipeline
   always @(posedge i_clk) begin
      if (i_rst) begin
         ref_q.delete();
         stall_pipe <= '1;
         out_seen   <= 1'b0;
      end else begin
         stall_pipe <= {stall_pipe[`MERGE_STAGES-2:0], i_stall};
         if (!i_out_stall) begin
            out_seen <= 1'b1;
            if (ref_q.size() > 0) begin
               void'(ref_q.pop_front());
            end
         end
         if (!i_stall) begin
            ref_q.push_back({i_flag, i_exp_keys});
         end
      end
      have_front <= (ref_q.size() > 0);
      front      <= (ref_q.size() > 0) ? ref_q[0] : '0;
      o_pending  <= ref_q.size();
   end

   a_ascending: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_out_stall |-> keys_ascending(out_keys))
      else count_mismatch("output keys not ascending");
   a_keys: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_out_stall |-> have_front && out_keys == front[EXP_W-1:0])
      else count_mismatch("output keys differ from sorted input beat");
   a_flag: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_out_stall |-> i_out_flag == front[EXP_W])
      else count_mismatch("switch flag differs from its input beat");
   a_latency: assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_stall == stall_pipe[`MERGE_STAGES-1])
      else count_mismatch("stall token not delayed by four cycles");
   a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_stall && out_seen |-> $stable(out_keys) && $stable(i_out_flag))
      else count_mismatch("outputs changed during a stall bubble");
   // Nothing but bubbles between reset and the first output beat
   a_idle_flag: assert property (@(posedge i_clk) disable iff (i_rst)
      !out_seen && i_out_stall |-> !i_out_flag)
      else count_mismatch("switch flag high before the first beat");

endmodule

// File: bench/tb_bitonic_merge.sv
// --------------------
// Testbench for the bitonic merge, directed and LFSR beats with stall bubbles
// --------------------
`timescale 1ns/1ns
`include "merge_config.svh"

module tb_bitonic_merge;
   import key_pkg::*;
   import network_pkg::*;

   localparam int LANES         = `MERGE_HALF_LANES;
   localparam int KW            = `MERGE_KEY_WIDTH;
   localparam int EXP_W         = 2 * LANES * KW;
   localparam int DRAIN_TIMEOUT = 40;

   logic             i_clk;
   logic             i_rst;
   logic             i_stall;
   logic             i_switch_output;
   lanes_t           i_elems_lo;
   lanes_t           i_elems_hi;
   lanes_t           o_elems_lo;
   lanes_t           o_elems_hi;
   logic             o_switch_output;
   logic             o_stall;
   logic [EXP_W-1:0] exp_keys;
   logic [31:0]      lfsr_state;
   int               check_errors;
   int               pending;
   int               timeout_count;

   bitonic_merge_top DUT (.*);

   merge_ref_check u_check (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_stall     (i_stall),
      .i_flag      (i_switch_output),
      .i_exp_keys  (exp_keys),
      .i_out_lo    (o_elems_lo),
      .i_out_hi    (o_elems_hi),
      .i_out_flag  (o_switch_output),
      .i_out_stall (o_stall),
      .o_errors    (check_errors),
      .o_pending   (pending)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int b = 0; b < n; b++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r          = {r[30:0], fb};
      end
      return r;
   endfunction

   // Insertion sort on the lowest n keys of a packed vector
   function automatic logic [EXP_W-1:0] sort_keys(input logic [EXP_W-1:0] v, input int n);
      key_t t;
      for (int i = 1; i < n; i++) begin
         for (int j = i; j > 0; j--) begin
            if (v[j*KW +: KW] < v[(j-1)*KW +: KW]) begin
               t                 = v[j*KW +: KW];
               v[j*KW +: KW]     = v[(j-1)*KW +: KW];
               v[(j-1)*KW +: KW] = t;
            end
         end
      end
      return v;
   endfunction

   function automatic lanes_t sorted_group(input lanes_t g);
      logic [EXP_W-1:0] v;
      v = sort_keys(EXP_W'(g), LANES);
      return v[LANES*KW-1:0];
   endfunction

   function automatic lanes_t random_group();
      lanes_t g;
      for (int i = 0; i < LANES; i++) begin
         g[i] = take_bits(KW);
      end
      return sorted_group(g);
   endfunction

   function automatic lanes_t ramp_group(input key_t base, input key_t step);
      lanes_t g;
      for (int i = 0; i < LANES; i++) begin
         g[i] = base + key_t'(i) * step;
      end
      return g;
   endfunction

   task automatic drive_beat(input lanes_t lo, input lanes_t hi, input logic stall,
                             input logic flag);
      @(posedge i_clk);
      i_elems_lo      <= lo;
      i_elems_hi      <= hi;
      i_stall         <= stall;
      i_switch_output <= flag;
      exp_keys        <= sort_keys({hi, lo}, 2 * LANES);
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      @(posedge i_clk);
      i_stall <= 1'b1;
      // Queue count lags the last push by one edge
      @(posedge i_clk);
      while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
         @(posedge i_clk);
         cycles++;
      end
      if (pending != 0) begin
         $display("Timeout: %0d beats never left the pipeline", pending);
         timeout_count++;
      end
   endtask

   task automatic run_directed();
      drive_beat(ramp_group(32'h5a5a_0123, 0), ramp_group(32'h5a5a_0123, 0), 1'b0, 1'b1);
      drive_beat(random_group(), random_group(), 1'b1, 1'b0);
      // Wrapping ramps give both 0 and the largest key, with duplicates
      drive_beat(sorted_group(ramp_group(32'hffff_fffd, 1)),
                 sorted_group(ramp_group(32'hffff_fffe, 1)), 1'b0, 1'b0);
      drive_beat(ramp_group(32'd1000, 1), ramp_group(32'd0, 3), 1'b0, 1'b1);
      repeat (3) drive_beat(random_group(), random_group(), 1'b1, 1'b1);
      drive_beat(ramp_group(32'd0, 2), ramp_group(32'd1, 2), 1'b0, 1'b0);
   endtask

   initial begin
      logic [31:0] bits;
      i_rst           = 1'b1;
      i_stall         = 1'b1;
      i_switch_output = 1'b0;
      i_elems_lo      = '0;
      i_elems_hi      = '0;
      exp_keys        = '0;
      lfsr_state      = 32'h394c;
      timeout_count   = 0;
      repeat (5) @(posedge i_clk);
      i_rst <= 1'b0;
      run_directed();
      wait_drain();
      // About one beat in four is a bubble
      for (int n = 0; n < 300; n++) begin
         bits = take_bits(3);
         drive_beat(random_group(), random_group(), bits[1:0] == 2'b00, bits[2]);
      end
      wait_drain();
      $display("Errors: %0d mismatches, %0d timeouts", check_errors, timeout_count);
      if (check_errors == 0 && timeout_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+src
src/key_pkg.sv
src/network_pkg.sv
src/merge_stage_if.sv
src/bitonic_split_stage.sv
src/half_cleaner_stage.sv
src/bitonic_merge_top.sv
bench/merge_ref_check.sv
bench/tb_bitonic_merge.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bitonic_merge
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
